// ==== verilog/pattern_gen_settings.svh ====
//==========================================================================
// Pattern generator settings
// Sample width, buffer depth and register map offsets
//==========================================================================
`ifndef PATTERN_GEN_SETTINGS_SVH
`define PATTERN_GEN_SETTINGS_SVH

// Bits per sample
`define PG_NUM_SIG 8
// Depth of the write and read buffers
`define PG_NUM_SAMP 32
// Buffer index width and buffer length width (length counts up to depth)
`define PG_PTR_W $clog2(`PG_NUM_SAMP)
`define PG_LEN_W $clog2(`PG_NUM_SAMP + 1)

// Register byte offsets
`define PG_ADDR_CONTROL 8'h00
`define PG_ADDR_WRITE_CHANNEL 8'h04
`define PG_ADDR_READ_CHANNEL 8'h08
`define PG_ADDR_N_SAMPLES 8'h0C
`define PG_ADDR_SAMPLE_COUNT 8'h10
`define PG_ADDR_STATUS 8'h14

`endif

// ==== verilog/pattern_regs_pkg.sv ====
//==========================================================================
// Pattern generator register map types
// Control register views and register offset enum
//==========================================================================
`default_nettype none

`include "pattern_gen_settings.svh"

package pattern_regs_pkg;

   // Control register, read back raw and decoded as fields
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic [5:0] reserved;
         // Write-only, starts a run
         logic       run;
         // Replay the buffer until cleared
         logic       loop;
      } fields;
   } control_reg_t;

   // Register offsets on the strobe bus
   typedef enum logic [7:0] {
      REG_CONTROL       = `PG_ADDR_CONTROL,
      REG_WRITE_CHANNEL = `PG_ADDR_WRITE_CHANNEL,
      REG_READ_CHANNEL  = `PG_ADDR_READ_CHANNEL,
      REG_N_SAMPLES     = `PG_ADDR_N_SAMPLES,
      REG_SAMPLE_COUNT  = `PG_ADDR_SAMPLE_COUNT,
      REG_STATUS        = `PG_ADDR_STATUS
   } reg_addr_t;

endpackage

`default_nettype wire

// ==== verilog/pattern_wave_pkg.sv ====
//==========================================================================
// Pattern generator sequencer types
// State encoding shared by the sequencer and the status register
//==========================================================================
`default_nettype none

package pattern_wave_pkg;

   // Sequencer states in the wave_clk domain
   typedef enum logic [1:0] {
      WAVE_IDLE        = 2'd0,
      WAVE_TRANSACTION = 2'd1,
      WAVE_DONE        = 2'd2
   } wave_state_t;

endpackage

`default_nettype wire

// ==== verilog/pattern_reg_file.sv ====
//==========================================================================
// Pattern generator register file
// Strobe bus decode, control and sample count registers, read mux
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "pattern_gen_settings.svh"

module pattern_reg_file
   import pattern_regs_pkg::*;
   import pattern_wave_pkg::*;
(
   input  wire                     axi_clk,
   input  wire                     axi_resetn,
   input  wire  [7:0]              reg_addr,
   input  wire                     reg_wr,
   input  wire  [31:0]             reg_wdata,
   input  wire                     reg_rd,
   output logic [31:0]             reg_rdata,
   output logic                    write_strobe,
   output logic [`PG_NUM_SIG-1:0]  write_sample,
   output logic                    read_strobe,
   output logic                    run_pulse,
   output logic                    loop,
   output logic [`PG_LEN_W-1:0]    n_samples_clamped,
   input  wire  [`PG_NUM_SIG-1:0]  read_sample,
   input  wire  [`PG_LEN_W-1:0]    write_buffer_len,
   input  wire  [`PG_PTR_W-1:0]    next_read_sample,
   input  wire  [31:0]             sample_count,
   input  wire                     triggered,
   input  wire  wave_state_t       seq_state
);

   localparam int LEN_W = `PG_LEN_W;

   reg_addr_t    addr;
   control_reg_t ctrl;
   control_reg_t wdata_ctrl;
   logic [31:0]  n_samples;
   logic         wr_control;
   logic         wr_n_samples;

   assign addr = reg_addr_t'(reg_addr);
   assign wdata_ctrl.raw = reg_wdata[7:0];

   // Write decode
   assign wr_control = reg_wr && (addr == REG_CONTROL);
   // Sample count is frozen while a run uses it
   assign wr_n_samples = reg_wr && (addr == REG_N_SAMPLES) && !triggered;
   assign write_strobe = reg_wr && (addr == REG_WRITE_CHANNEL);
   assign write_sample = reg_wdata[`PG_NUM_SIG-1:0];

   // Read decode, advances the read pointer after this read
   assign read_strobe = reg_rd && (addr == REG_READ_CHANNEL);

   // Run is a pulse, never stored
   assign run_pulse = wr_control && wdata_ctrl.fields.run;
   assign loop = ctrl.fields.loop;

   // Never play past the end of the buffer
   assign n_samples_clamped = (n_samples > `PG_NUM_SAMP) ?
                              LEN_W'(`PG_NUM_SAMP) : LEN_W'(n_samples);

   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         ctrl.raw  <= '0;
         n_samples <= '0;
      end else begin
         if (wr_control) begin
            ctrl <= wdata_ctrl;
            ctrl.fields.run <= 1'b0;
         end
         if (wr_n_samples)
            n_samples <= reg_wdata;
      end
   end

   // Registered read mux, data valid the cycle after reg_rd
   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         reg_rdata <= '0;
      end else if (reg_rd) begin
         case (addr)
            REG_CONTROL:      reg_rdata <= {24'd0, ctrl.raw};
            REG_READ_CHANNEL: reg_rdata <= 32'(read_sample);
            REG_N_SAMPLES:    reg_rdata <= n_samples;
            REG_SAMPLE_COUNT: reg_rdata <= sample_count;
            // Status: [17] triggered, [16:15] state, [14:8] read ptr, [7:0] length
            REG_STATUS: reg_rdata <= {14'd0, triggered, seq_state,
                                      7'(next_read_sample), 8'(write_buffer_len)};
            // WRITE_CHANNEL is write-only
            default:          reg_rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pattern_buffers.sv ====
//==========================================================================
// Pattern generator sample buffers
// Write and read sample storage, axi-side pointers and the run/done
// handshake between the axi_clk and wave_clk domains
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "pattern_gen_settings.svh"

module pattern_buffers (
   input  wire                     axi_clk,
   input  wire                     wave_clk,
   input  wire                     axi_resetn,
   input  wire                     write_strobe,
   input  wire  [`PG_NUM_SIG-1:0]  write_sample,
   input  wire                     read_strobe,
   input  wire                     run_pulse,
   output logic [`PG_NUM_SIG-1:0]  read_sample,
   output logic [`PG_LEN_W-1:0]    write_buffer_len,
   output logic [`PG_PTR_W-1:0]    next_read_sample,
   output logic                    triggered,
   output logic [31:0]             sample_count,
   input  wire                     seq_done,
   input  wire  [31:0]             seq_count,
   input  wire  [`PG_PTR_W-1:0]    wave_ptr,
   input  wire                     capture_en,
   input  wire  [`PG_PTR_W-1:0]    capture_ptr,
   input  wire  [`PG_NUM_SIG-1:0]  capture_sample,
   output logic [`PG_NUM_SIG-1:0]  play_sample,
   output logic                    trig_sync,
   output logic                    loop_sync,
   input  wire                     loop
);

   localparam int NUM_SIG  = `PG_NUM_SIG;
   localparam int NUM_SAMP = `PG_NUM_SAMP;
   localparam int PTR_W    = `PG_PTR_W;

   logic [NUM_SAMP-1:0][NUM_SIG-1:0] write_buffer;
   logic [NUM_SAMP-1:0][NUM_SIG-1:0] read_buffer;

   logic trig_level;
   logic trig_meta;
   logic loop_meta;
   logic done_meta;
   logic done_sync;
   logic done_event;
   logic write_ok;

   // Busy until the sequencer done level has dropped again, so a new run
   // never lands while the sequencer still sits in done
   assign triggered = trig_level | done_sync;

   // Done seen on the axi side, one cycle wide
   assign done_event = trig_level & done_sync;

   // No writes while busy, none past the last entry
   assign write_ok = write_strobe && !triggered && (write_buffer_len < NUM_SAMP);

   // Both buffers are stable while the other domain reads them
   assign play_sample = write_buffer[wave_ptr];
   assign read_sample = read_buffer[next_read_sample];

   always_ff @(posedge axi_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         trig_level       <= 1'b0;
         done_meta        <= 1'b0;
         done_sync        <= 1'b0;
         write_buffer_len <= '0;
         next_read_sample <= '0;
         sample_count     <= '0;
         write_buffer     <= '0;
      end else begin
         // Done level back into axi_clk
         done_meta <= seq_done;
         done_sync <= done_meta;
         if (done_event) begin
            // Run finished: new data to read, buffer free to refill
            trig_level       <= 1'b0;
            write_buffer_len <= '0;
            next_read_sample <= '0;
            // Sequencer holds its count while in done
            sample_count     <= seq_count;
         end else begin
            if (run_pulse && !triggered)
               trig_level <= 1'b1;
            if (write_ok) begin
               write_buffer[write_buffer_len[PTR_W-1:0]] <= write_sample;
               write_buffer_len <= write_buffer_len + 1'b1;
            end
            // Saturate on the last entry
            if (read_strobe && (next_read_sample != PTR_W'(NUM_SAMP - 1)))
               next_read_sample <= next_read_sample + 1'b1;
         end
      end
   end

   always_ff @(posedge wave_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         trig_meta   <= 1'b0;
         trig_sync   <= 1'b0;
         loop_meta   <= 1'b0;
         loop_sync   <= 1'b0;
         read_buffer <= '0;
      end else begin
         // Trigger and loop levels into wave_clk
         trig_meta <= trig_level;
         trig_sync <= trig_meta;
         loop_meta <= loop;
         loop_sync <= loop_meta;
         // Captured inputs, written only in the wave domain
         if (capture_en)
            read_buffer[capture_ptr] <= capture_sample;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pattern_sequencer.sv ====
//==========================================================================
// Pattern generator sequencer
// Plays buffered samples on wave_clk, captures inputs one cycle behind
// and counts samples played
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "pattern_gen_settings.svh"

module pattern_sequencer
   import pattern_wave_pkg::*;
(
   input  wire                     wave_clk,
   input  wire                     axi_resetn,
   input  wire                     trig_sync,
   input  wire                     loop_sync,
   input  wire  [`PG_LEN_W-1:0]    n_samples_clamped,
   input  wire  [`PG_NUM_SIG-1:0]  play_sample,
   input  wire  [`PG_NUM_SIG-1:0]  input_signals,
   output logic [`PG_NUM_SIG-1:0]  output_signals,
   output logic [`PG_PTR_W-1:0]    wave_ptr,
   output logic                    capture_en,
   output logic [`PG_PTR_W-1:0]    capture_ptr,
   output logic [`PG_NUM_SIG-1:0]  capture_sample,
   output logic                    seq_done,
   output logic [31:0]             seq_count,
   output wave_state_t             seq_state
);

   localparam int LEN_W = `PG_LEN_W;

   logic                  last_sample;
   logic                  cap_valid;
   logic [`PG_PTR_W-1:0]  cap_ptr;

   // Pointer sits on the final sample of the run
   assign last_sample = ((LEN_W'(wave_ptr) + 1'b1) == n_samples_clamped);

   always_ff @(posedge wave_clk or negedge axi_resetn) begin
      if (!axi_resetn) begin
         seq_state      <= WAVE_IDLE;
         wave_ptr       <= '0;
         output_signals <= '0;
         seq_done       <= 1'b0;
         seq_count      <= '0;
         cap_valid      <= 1'b0;
         cap_ptr        <= '0;
         capture_en     <= 1'b0;
         capture_ptr    <= '0;
         capture_sample <= '0;
      end else begin
         // Capture pipeline: index of the sample now on the pins, then the
         // input one cycle later
         cap_valid      <= (seq_state == WAVE_TRANSACTION);
         cap_ptr        <= wave_ptr;
         capture_en     <= cap_valid;
         capture_ptr    <= cap_ptr;
         capture_sample <= input_signals;

         case (seq_state)
            WAVE_IDLE: begin
               output_signals <= '0;
               wave_ptr       <= '0;
               seq_done       <= 1'b0;
               if (trig_sync)
                  // Empty run goes straight to done
                  seq_state <= (n_samples_clamped == '0) ? WAVE_DONE : WAVE_TRANSACTION;
            end
            WAVE_TRANSACTION: begin
               output_signals <= play_sample;
               seq_count      <= seq_count + 1'b1;
               if (last_sample) begin
                  // Wrap in loop mode, else stop after this one
                  wave_ptr <= '0;
                  if (!loop_sync)
                     seq_state <= WAVE_DONE;
               end else begin
                  wave_ptr <= wave_ptr + 1'b1;
               end
            end
            WAVE_DONE: begin
               output_signals <= '0;
               wave_ptr       <= '0;
               // Report done only once the last capture is written
               seq_done       <= !cap_valid && !capture_en;
               if (!trig_sync) begin
                  seq_state <= WAVE_IDLE;
                  seq_done  <= 1'b0;
               end
            end
            default: seq_state <= WAVE_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/pattern_gen_top.sv ====
//==========================================================================
// Pattern generator top level
// Register file, sample buffers and wave_clk sequencer
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "pattern_gen_settings.svh"

module pattern_gen_top
   import pattern_wave_pkg::*;
(
   input  wire                     axi_clk,
   input  wire                     wave_clk,
   input  wire                     axi_resetn,
   input  wire  [7:0]              reg_addr,
   input  wire                     reg_wr,
   input  wire  [31:0]             reg_wdata,
   input  wire                     reg_rd,
   output logic [31:0]             reg_rdata,
   output logic [`PG_NUM_SIG-1:0]  output_signals,
   input  wire  [`PG_NUM_SIG-1:0]  input_signals
);

   // Register file to buffers
   logic                    write_strobe;
   logic [`PG_NUM_SIG-1:0]  write_sample;
   logic                    read_strobe;
   logic                    run_pulse;
   logic                    loop;
   logic [`PG_LEN_W-1:0]    n_samples_clamped;

   // Buffers to register file
   logic [`PG_NUM_SIG-1:0]  read_sample;
   logic [`PG_LEN_W-1:0]    write_buffer_len;
   logic [`PG_PTR_W-1:0]    next_read_sample;
   logic [31:0]             sample_count;
   logic                    triggered;

   // Between buffers and sequencer
   wave_state_t             seq_state;
   logic                    seq_done;
   logic [31:0]             seq_count;
   logic [`PG_PTR_W-1:0]    wave_ptr;
   logic                    capture_en;
   logic [`PG_PTR_W-1:0]    capture_ptr;
   logic [`PG_NUM_SIG-1:0]  capture_sample;
   logic [`PG_NUM_SIG-1:0]  play_sample;
   logic                    trig_sync;
   logic                    loop_sync;

   pattern_reg_file pattern_reg_file_inst (
      .axi_clk           (axi_clk),
      .axi_resetn        (axi_resetn),
      .reg_addr          (reg_addr),
      .reg_wr            (reg_wr),
      .reg_wdata         (reg_wdata),
      .reg_rd            (reg_rd),
      .reg_rdata         (reg_rdata),
      .write_strobe      (write_strobe),
      .write_sample      (write_sample),
      .read_strobe       (read_strobe),
      .run_pulse         (run_pulse),
      .loop              (loop),
      .n_samples_clamped (n_samples_clamped),
      .read_sample       (read_sample),
      .write_buffer_len  (write_buffer_len),
      .next_read_sample  (next_read_sample),
      .sample_count      (sample_count),
      .triggered         (triggered),
      .seq_state         (seq_state)
   );

   pattern_buffers pattern_buffers_inst (
      .axi_clk          (axi_clk),
      .wave_clk         (wave_clk),
      .axi_resetn       (axi_resetn),
      .write_strobe     (write_strobe),
      .write_sample     (write_sample),
      .read_strobe      (read_strobe),
      .run_pulse        (run_pulse),
      .read_sample      (read_sample),
      .write_buffer_len (write_buffer_len),
      .next_read_sample (next_read_sample),
      .triggered        (triggered),
      .sample_count     (sample_count),
      .seq_done         (seq_done),
      .seq_count        (seq_count),
      .wave_ptr         (wave_ptr),
      .capture_en       (capture_en),
      .capture_ptr      (capture_ptr),
      .capture_sample   (capture_sample),
      .play_sample      (play_sample),
      .trig_sync        (trig_sync),
      .loop_sync        (loop_sync),
      .loop             (loop)
   );

   pattern_sequencer pattern_sequencer_inst (
      .wave_clk          (wave_clk),
      .axi_resetn        (axi_resetn),
      .trig_sync         (trig_sync),
      .loop_sync         (loop_sync),
      .n_samples_clamped (n_samples_clamped),
      .play_sample       (play_sample),
      .input_signals     (input_signals),
      .output_signals    (output_signals),
      .wave_ptr          (wave_ptr),
      .capture_en        (capture_en),
      .capture_ptr       (capture_ptr),
      .capture_sample    (capture_sample),
      .seq_done          (seq_done),
      .seq_count         (seq_count),
      .seq_state         (seq_state)
   );

endmodule

`default_nettype wire

// ==== verification/pattern_gen_tb.sv ====
//==========================================================================
// Pattern generator testbench
// Table-driven runs through the register bus with an inverting loopback,
// checking playback, capture readback, clamping and sample counting
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

`include "pattern_gen_settings.svh"

module pattern_gen_tb;

   localparam int NUM_SAMP  = `PG_NUM_SAMP;
   localparam int NUM_TESTS = 5;

   // Columns: samples written, N_SAMPLES, loop, stored length, reads, writes while busy
   int n_write_tab [0:NUM_TESTS-1] = '{8, 40, 12, 16, 20};
   int n_samp_tab  [0:NUM_TESTS-1] = '{8, 40, 12, 16, 6};
   int loop_tab    [0:NUM_TESTS-1] = '{0, 0, 1, 0, 0};
   int exp_len_tab [0:NUM_TESTS-1] = '{8, 32, 12, 16, 20};
   int reads_tab   [0:NUM_TESTS-1] = '{8, 34, 12, 16, 6};
   int busy_tab    [0:NUM_TESTS-1] = '{0, 0, 0, 3, 0};

   logic                    axi_clk;
   logic                    wave_clk;
   logic                    axi_resetn;
   logic [7:0]              reg_addr;
   logic                    reg_wr;
   logic [31:0]             reg_wdata;
   logic                    reg_rd;
   wire  [31:0]             reg_rdata;
   wire  [`PG_NUM_SIG-1:0]  output_signals;
   wire  [`PG_NUM_SIG-1:0]  input_signals;

   logic [15:0]             lfsr_state;
   logic [`PG_NUM_SIG-1:0]  pattern [0:63];
   logic [31:0]             expected_count;
   int                      error_count;
   int                      test_errors;
   int                      tests_failed;
   int                      cycle_count;
   int                      cycle_limit;

   pattern_gen_top pattern_gen_top_inst (
      .axi_clk        (axi_clk),
      .wave_clk       (wave_clk),
      .axi_resetn     (axi_resetn),
      .reg_addr       (reg_addr),
      .reg_wr         (reg_wr),
      .reg_wdata      (reg_wdata),
      .reg_rd         (reg_rd),
      .reg_rdata      (reg_rdata),
      .output_signals (output_signals),
      .input_signals  (input_signals)
   );

   // Loopback, inputs see the inverted outputs
   assign input_signals = ~output_signals;

   // 40 ns register clock, 60 ns wave clock
   always #20 axi_clk = ~axi_clk;
   always #30 wave_clk = ~wave_clk;

   // Run length guard
   always @(posedge axi_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout after %0d axi_clk cycles, the run did not finish", cycle_count);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per sample bit
   task automatic draw_sample(output logic [`PG_NUM_SIG-1:0] value);
      int b;
      for (b = 0; b < `PG_NUM_SIG; b++) begin
         value[b]   = lfsr_state[15];
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // Cycle allowance for one table row
   function automatic int test_budget(input int t);
      test_budget = 4 * (n_write_tab[t] + reads_tab[t] + busy_tab[t]) + 8 * NUM_SAMP + 200;
      // Loop rows hold the run for several passes
      if (loop_tab[t] != 0)
         test_budget = test_budget + 10 * NUM_SAMP;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
      if (got !== expected) begin
         $display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                  $time, name, got, expected);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic flag_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      error_count++;
      test_errors++;
   endtask

   // Called on a falling edge, returns on the next one
   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
      reg_addr  = addr;
      reg_wdata = data;
      reg_wr    = 1'b1;
      @(negedge axi_clk);
      reg_wr    = 1'b0;
   endtask

   // Read data is registered, so it is taken one falling edge later
   task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
      reg_addr = addr;
      reg_rd   = 1'b1;
      @(negedge axi_clk);
      reg_rd   = 1'b0;
      data     = reg_rdata;
   endtask

   // Poll STATUS until triggered drops
   task automatic wait_run_done();
      logic [31:0] status;
      status = 32'h0002_0000;
      while (status[17])
         reg_read(`PG_ADDR_STATUS, status);
   endtask

   task automatic report_test(input int num, input string desc);
      if (test_errors == 0) begin
         $display("Test %0d %s: ok", num, desc);
      end else begin
         $display("Test %0d %s: %0d errors", num, desc, test_errors);
         tests_failed++;
      end
   endtask

   initial begin
      logic [31:0]             rdata;
      logic [31:0]             prev_count;
      logic [`PG_NUM_SIG-1:0]  busy_sample;
      int                      clamped;
      int                      idx;
      int                      t;
      int                      i;

      axi_clk        = 1'b0;
      wave_clk       = 1'b0;
      axi_resetn     = 1'b0;
      reg_addr       = 8'h00;
      reg_wr         = 1'b0;
      reg_wdata      = 32'h0;
      reg_rd         = 1'b0;
      lfsr_state     = 16'd61144;
      expected_count = 32'h0;
      error_count    = 0;
      tests_failed   = 0;
      cycle_count    = 0;
      cycle_limit    = 200;
      for (t = 0; t < NUM_TESTS; t++)
         cycle_limit = cycle_limit + test_budget(t);

      repeat (10) @(posedge axi_clk);
      @(negedge axi_clk);
      axi_resetn = 1'b1;
      @(negedge axi_clk);

      // Reset values; STATUS first, a READ_CHANNEL read moves the pointer
      test_errors = 0;
      compare_value("output_signals", 32'(output_signals), 32'h0);
      reg_read(`PG_ADDR_STATUS, rdata);
      compare_value("status", rdata, 32'h0);
      reg_read(`PG_ADDR_CONTROL, rdata);
      compare_value("control", rdata & 32'hFFFF_FF03, 32'h0);
      reg_read(`PG_ADDR_N_SAMPLES, rdata);
      compare_value("n_samples", rdata, 32'h0);
      reg_read(`PG_ADDR_SAMPLE_COUNT, rdata);
      compare_value("sample_count", rdata, 32'h0);
      reg_read(`PG_ADDR_WRITE_CHANNEL, rdata);
      compare_value("write_channel", rdata, 32'h0);
      reg_read(`PG_ADDR_READ_CHANNEL, rdata);
      compare_value("read_channel", rdata, 32'h0);
      report_test(0, "reset values");

      for (t = 0; t < NUM_TESTS; t++) begin
         test_errors = 0;
         clamped = (n_samp_tab[t] > NUM_SAMP) ? NUM_SAMP : n_samp_tab[t];

         // Fill the write buffer, extra writes past the depth are dropped
         for (i = 0; i < n_write_tab[t]; i++) begin
            draw_sample(pattern[i]);
            reg_write(`PG_ADDR_WRITE_CHANNEL, 32'(pattern[i]));
         end
         reg_read(`PG_ADDR_STATUS, rdata);
         compare_value("status length", 32'(rdata[7:0]), exp_len_tab[t]);

         reg_write(`PG_ADDR_N_SAMPLES, n_samp_tab[t]);
         reg_read(`PG_ADDR_N_SAMPLES, rdata);
         compare_value("n_samples", rdata, n_samp_tab[t]);

         // Run bit plus loop from the table; run reads back as zero
         reg_write(`PG_ADDR_CONTROL, (loop_tab[t] != 0) ? 32'h3 : 32'h2);
         reg_read(`PG_ADDR_CONTROL, rdata);
         compare_value("control", rdata, loop_tab[t]);
         reg_read(`PG_ADDR_STATUS, rdata);
         compare_value("status triggered", 32'(rdata[17]), 32'd1);

         // Writes during the run must not land
         for (i = 0; i < busy_tab[t]; i++) begin
            draw_sample(busy_sample);
            reg_write(`PG_ADDR_WRITE_CHANNEL, 32'(busy_sample));
         end
         if (busy_tab[t] > 0) begin
            reg_read(`PG_ADDR_STATUS, rdata);
            compare_value("status length while busy", 32'(rdata[7:0]), exp_len_tab[t]);
         end

         if (loop_tab[t] != 0) begin
            // Several passes at 60 ns per sample
            repeat (5 * clamped + 20) @(negedge axi_clk);
            reg_read(`PG_ADDR_STATUS, rdata);
            compare_value("status triggered in loop", 32'(rdata[17]), 32'd1);
            reg_write(`PG_ADDR_CONTROL, 32'h0);
         end

         wait_run_done();
         compare_value("output_signals after run", 32'(output_signals), 32'h0);
         // Idle, pointers cleared by the end of the run
         reg_read(`PG_ADDR_STATUS, rdata);
         compare_value("status after run", rdata, 32'h0);

         prev_count = expected_count;
         reg_read(`PG_ADDR_SAMPLE_COUNT, rdata);
         if (loop_tab[t] != 0) begin
            // Loop runs stop on the last sample, so whole passes only
            compare_value("sample_count pass remainder",
                          (rdata - prev_count) % 32'(clamped), 32'h0);
            if ((rdata - prev_count) < 32'(2 * clamped))
               flag_error("loop run played fewer than two passes");
            expected_count = rdata;
         end else begin
            expected_count = prev_count + 32'(clamped);
            compare_value("sample_count", rdata, expected_count);
         end

         // Captured inputs, last entry repeats once the pointer saturates
         for (i = 0; i < reads_tab[t]; i++) begin
            idx = (i < NUM_SAMP - 1) ? i : NUM_SAMP - 1;
            reg_read(`PG_ADDR_READ_CHANNEL, rdata);
            compare_value($sformatf("read_channel[%0d]", i), rdata,
                          {24'd0, ~pattern[idx]});
         end
         reg_read(`PG_ADDR_STATUS, rdata);
         compare_value("status read pointer", 32'(rdata[14:8]),
                       (reads_tab[t] < NUM_SAMP) ? reads_tab[t] : NUM_SAMP - 1);

         report_test(t + 1, $sformatf("write %0d n_samples %0d loop %0d",
                                      n_write_tab[t], n_samp_tab[t], loop_tab[t]));
      end

      $display("Tests run: %0d, failed: %0d, errors: %0d",
               NUM_TESTS + 1, tests_failed, error_count);
      if (error_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verilog
verilog/pattern_regs_pkg.sv
verilog/pattern_wave_pkg.sv
verilog/pattern_reg_file.sv
verilog/pattern_buffers.sv
verilog/pattern_sequencer.sv
verilog/pattern_gen_top.sv
verification/pattern_gen_tb.sv

// ==== Bender.yml ====
package:
  name: pattern_gen

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pattern_regs_pkg.sv
      - verilog/pattern_wave_pkg.sv
      - verilog/pattern_reg_file.sv
      - verilog/pattern_buffers.sv
      - verilog/pattern_sequencer.sv
      - verilog/pattern_gen_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/pattern_gen_tb.sv
